// File: files.f
hw/bridge_pkg.sv
hw/dram_reader.sv
hw/sd_frame_tx.sv
hw/bridge_ctrl.sv
hw/byte_out.sv
hw/bridge_top.sv
verif/tb_clk_gen.sv
verif/tb_bridge.sv

// File: run.sh
#!/bin/sh
# build and run the DRAM to SD bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_bridge -f files.f -o sim_bridge

./obj_dir/sim_bridge > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    echo "simulation failed"
    exit 1
fi

echo "simulation passed"
exit 0

// File: verif/tb_bridge.sv
// DRAM to SD bridge testbench
// table of requests with DRAM and card delays, cycle stepped models
// of the DRAM read channels and of the SD card in SPI mode
`timescale 1ns/1ps

module tb_bridge import bridge_pkg::*; ();

    localparam int NUM_CASES  = 8;
    localparam int WAIT_LIMIT = 200;

    typedef logic [87:0] wide_t;

    typedef struct packed {
        dram_addr_t addr_dram;
        sd_addr_t   addr_sd;
        block_t     data;
        int         ar_dly;
        int         r_dly;
        int         resp_dly;
        int         busy_len;
    } case_t;

    logic         clk;
    logic         rst_n;
    logic         in_valid;
    bridge_req_t  req;
    dram_rd_req_t dram_req;
    dram_rd_rsp_t dram_rsp;
    logic         miso;
    logic         mosi;
    logic         out_valid;
    byte_t        out_data;

    case_t rows [NUM_CASES];
    int    errors;
    int    ar_beats;
    bit    aborted;
    bit    out_allowed;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    bridge_top uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .dram_req  (dram_req),
        .dram_rsp  (dram_rsp),
        .miso      (miso),
        .mosi      (mosi),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    // ##############################
    // reference models
    // ##############################
    // x^7 + x^3 + 1, register taps written out
    function automatic logic [6:0] crc7_model(input logic [39:0] bits);
        logic [6:0] r;
        logic       fb;
        r = 7'd0;
        for (int i = 39; i >= 0; i--) begin
            fb = bits[i] ^ r[6];
            r  = {r[5:3], r[2] ^ fb, r[1:0], fb};
        end
        return r;
    endfunction

    // x^16 + x^12 + x^5 + 1
    function automatic logic [15:0] crc16_model(input block_t bits);
        logic [15:0] r;
        logic        fb;
        r = 16'd0;
        for (int i = 63; i >= 0; i--) begin
            fb = bits[i] ^ r[15];
            r  = {r[14:12], r[11] ^ fb, r[10:5], r[4] ^ fb, r[3:0], fb};
        end
        return r;
    endfunction

    task automatic report_mismatch(input string name, input wide_t expected,
                                   input wide_t actual);
        errors++;
        $display("Fail %s: expected %h, actual %h", name, expected, actual);
    endtask

    task automatic note_timeout(input string what);
        errors++;
        aborted = 1'b1;
        $display("timeout: %s", what);
    endtask

    // one clock; outputs read 1 ns after the edge, inputs driven right after
    task automatic step();
        if (dram_req.ar_valid === 1'b1 && dram_rsp.ar_ready === 1'b1) begin
            ar_beats++;
        end
        if (out_valid === 1'b1 && !out_allowed) begin
            errors++;
            $display("out_valid went high before the card released busy");
        end
        @(posedge clk);
        #1;
    endtask

    // first bit already on mosi when called
    task automatic capture_bits(input int len, output wide_t bits);
        bits = '1;
        for (int i = len - 1; i >= 0; i--) begin
            bits[i] = mosi;
            step();
        end
    endtask

    // card answer byte, msb first, mosi must stay idle meanwhile
    task automatic send_card_byte(input byte_t value, input int lead, input string tag);
        for (int i = 0; i < lead + 8; i++) begin
            miso = (i < lead) ? 1'b1 : value[7 - (i - lead)];
            if (mosi !== 1'b1) begin
                report_mismatch($sformatf("%s mosi idle", tag), wide_t'(1), wide_t'(mosi));
            end
            step();
        end
        miso = 1'b1;
    endtask

    task automatic load_table();
        // addr_dram, addr_sd, data, ar delay, r delay, response delay, busy length
        rows[0] = '{13'h0000, 16'h0000, 64'h0000_0000_0000_0000, 0, 0, 0, 2};
        rows[1] = '{13'h1fff, 16'hffff, 64'hffff_ffff_ffff_ffff, 3, 2, 1, 4};
        rows[2] = '{13'h0123, 16'h0042, 64'h0123_4567_89ab_cdef, 1, 0, 2, 3};
        rows[3] = '{13'h1a5c, 16'h8001, 64'hdead_beef_0bad_f00d, 0, 4, 0, 6};
        rows[4] = '{13'h0800, 16'h1234, 64'h8000_0000_0000_0001, 5, 1, 3, 2};
        for (int i = 5; i < NUM_CASES; i++) begin
            rows[i].addr_dram = dram_addr_t'($urandom);
            rows[i].addr_sd   = sd_addr_t'($urandom);
            rows[i].data      = {$urandom, $urandom};
            rows[i].ar_dly    = int'($urandom_range(6, 0));
            rows[i].r_dly     = int'($urandom_range(6, 0));
            rows[i].resp_dly  = int'($urandom_range(4, 0));
            rows[i].busy_len  = int'($urandom_range(9, 2));
        end
    endtask

    // ##############################
    // one request end to end
    // ##############################
    task automatic run_case(input int idx);
        case_t       c;
        string       tag;
        axi_addr_t   exp_addr;
        logic [39:0] head;
        wide_t       frame;
        int          n;
        c        = rows[idx];
        tag      = $sformatf("case %0d", idx);
        exp_addr = {19'd0, c.addr_dram};
        head     = {2'b01, 6'd24, 16'h0000, c.addr_sd};
        ar_beats = 0;

        req               = '{addr_dram: c.addr_dram, addr_sd: c.addr_sd};
        in_valid          = 1'b1;
        dram_rsp.ar_ready = 1'b0;
        step();
        in_valid = 1'b0;
        req      = '0;

        // address beat held through the ar_ready delay
        for (n = 0; n <= c.ar_dly; n++) begin
            if (dram_req.ar_valid !== 1'b1 || dram_req.ar_addr !== exp_addr) begin
                report_mismatch($sformatf("%s ar channel", tag), wide_t'({1'b1, exp_addr}),
                                wide_t'({dram_req.ar_valid, dram_req.ar_addr}));
            end
            dram_rsp.ar_ready = (n == c.ar_dly);
            step();
        end
        // ready stays up, so a repeated address beat gets counted
        dram_rsp.ar_ready = 1'b1;

        n = 0;
        while (dram_req.r_ready !== 1'b1 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (dram_req.r_ready !== 1'b1) begin
            note_timeout($sformatf("%s never raised r_ready", tag));
            return;
        end
        for (n = 0; n <= c.r_dly; n++) begin
            dram_rsp.r_valid = (n == c.r_dly);
            dram_rsp.r_data  = (n == c.r_dly) ? c.data : ~c.data;
            step();
        end
        dram_rsp.r_valid = 1'b0;
        dram_rsp.r_data  = '0;

        n = 0;
        while (mosi !== 1'b0 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (mosi !== 1'b0) begin
            note_timeout($sformatf("%s no command frame on mosi", tag));
            return;
        end
        capture_bits(48, frame);
        if (frame[47:0] !== {head, crc7_model(head), 1'b1}) begin
            report_mismatch($sformatf("%s cmd frame", tag),
                            wide_t'({head, crc7_model(head), 1'b1}), wide_t'(frame[47:0]));
        end
        send_card_byte(8'h00, c.resp_dly, tag);

        n = 0;
        while (mosi !== 1'b0 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (mosi !== 1'b0) begin
            note_timeout($sformatf("%s no data frame on mosi", tag));
            return;
        end
        // first 0 is the last token bit, its seven ones look like idle
        capture_bits(81, frame);
        if (frame !== {8'hfe, c.data, crc16_model(c.data)}) begin
            report_mismatch($sformatf("%s data frame", tag),
                            {8'hfe, c.data, crc16_model(c.data)}, frame);
        end
        send_card_byte(8'h05, c.resp_dly, tag);

        // programming busy, then release
        for (n = 0; n < c.busy_len; n++) begin
            miso = 1'b0;
            step();
        end
        miso = 1'b1;
        step();
        // release sampled at that edge, burst may start one cycle later
        step();
        out_allowed = 1'b1;

        n = 0;
        while (out_valid !== 1'b1 && n < WAIT_LIMIT) begin
            step();
            n++;
        end
        if (out_valid !== 1'b1) begin
            note_timeout($sformatf("%s out_valid never rose", tag));
            return;
        end
        for (n = 0; n < 8; n++) begin
            if (out_valid !== 1'b1 || out_data !== c.data[63 - 8 * n -: 8]) begin
                report_mismatch($sformatf("%s byte %0d", tag, n),
                                wide_t'({1'b1, c.data[63 - 8 * n -: 8]}),
                                wide_t'({out_valid, out_data}));
            end
            step();
        end
        if (out_valid !== 1'b0) begin
            report_mismatch($sformatf("%s burst length", tag), wide_t'(0), wide_t'(out_valid));
        end
        out_allowed = 1'b0;
        if (ar_beats != 1) begin
            report_mismatch($sformatf("%s address beats", tag), wide_t'(1), wide_t'(ar_beats));
        end
    endtask

    initial begin
        int n;
        errors      = 0;
        aborted     = 1'b0;
        out_allowed = 1'b0;
        in_valid    = 1'b0;
        req         = '0;
        dram_rsp    = '0;
        miso        = 1'b1;
        void'($urandom(32'h4d61867a));
        load_table();

        n = 0;
        while (rst_n !== 1'b1 && n < 20) begin
            step();
            n++;
        end
        if (rst_n !== 1'b1) begin
            note_timeout("reset was never released");
        end
        step();

        // idle outputs after reset
        if (dram_req.ar_valid !== 1'b0 || dram_req.r_ready !== 1'b0 ||
            out_valid !== 1'b0 || out_data !== 8'h00 || mosi !== 1'b1) begin
            report_mismatch("reset state", wide_t'(12'h001),
                            wide_t'({dram_req.ar_valid, dram_req.r_ready, out_valid,
                                     out_data, mosi}));
        end

        for (int i = 0; i < NUM_CASES && !aborted; i++) begin
            run_case(i);
        end

        $display("checks done, %0d errors", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: verif/tb_clk_gen.sv
// testbench clock and reset
// 4 ns clock, reset held low for the first two cycles
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    initial begin
        rst_n = 1'b0;
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;
    end

endmodule

// File: hw/bridge_top.sv
// DRAM to SD card bridge, top level
// reads one 64-bit block from DRAM, writes it to the SD card with
// CMD24 in SPI mode, then streams it out as eight bytes
`timescale 1ns/1ps

module bridge_top import bridge_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         in_valid,
    input  bridge_req_t  req,
    output dram_rd_req_t dram_req,
    input  dram_rd_rsp_t dram_rsp,
    input  logic         miso,
    output logic         mosi,
    output logic         out_valid,
    output byte_t        out_data
);

    logic       rd_start;
    dram_addr_t rd_addr;
    logic       rd_done;
    block_t     block;
    sd_addr_t   sd_addr;
    logic       cmd_load;
    logic       data_load;
    logic       tx_done;
    logic       out_start;

    bridge_ctrl u_ctrl (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .req       (req),
        .rd_done   (rd_done),
        .tx_done   (tx_done),
        .miso      (miso),
        .rd_start  (rd_start),
        .rd_addr   (rd_addr),
        .sd_addr   (sd_addr),
        .cmd_load  (cmd_load),
        .data_load (data_load),
        .out_start (out_start)
    );

    dram_reader u_reader (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_start (rd_start),
        .rd_addr  (rd_addr),
        .dram_rsp (dram_rsp),
        .dram_req (dram_req),
        .rd_done  (rd_done),
        .block    (block)
    );

    sd_frame_tx u_sd_tx (
        .clk       (clk),
        .rst_n     (rst_n),
        .cmd_load  (cmd_load),
        .data_load (data_load),
        .sd_addr   (sd_addr),
        .block     (block),
        .mosi      (mosi),
        .tx_done   (tx_done)
    );

    byte_out u_byte_out (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_start (out_start),
        .block     (block),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

endmodule

// File: hw/byte_out.sv
// block output serializer
// copies the block on out_start and presents it as eight
// consecutive bytes, most significant byte first
`timescale 1ns/1ps

module byte_out import bridge_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   out_start,
    input  block_t block,
    output logic   out_valid,
    output byte_t  out_data
);

    block_t     data_q;
    logic [2:0] left_cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            out_data  <= '0;
            left_cnt  <= 3'd0;
        end else if (out_start) begin
            out_valid <= 1'b1;
            out_data  <= block[BLOCK_W-1 -: BYTE_W];
            left_cnt  <= 3'(BLOCK_BYTES - 1);
        end else if (left_cnt != 3'd0) begin
            out_data <= data_q[BLOCK_W-1 -: BYTE_W];
            left_cnt <= left_cnt - 3'd1;
        end else begin
            // burst over
            out_valid <= 1'b0;
            out_data  <= '0;
        end
    end

    // remaining bytes, shifted up one byte per cycle
    always_ff @(posedge clk) begin
        if (out_start) begin
            data_q <= block << BYTE_W;
        end else begin
            data_q <= data_q << BYTE_W;
        end
    end

endmodule

// File: hw/bridge_ctrl.sv
// bridge sequencer
// latches the request, starts the DRAM read, then walks the SD write
// sequence: command, response skip, gap, data frame, response skip,
// busy wait, and finally kicks off the byte output
`timescale 1ns/1ps

module bridge_ctrl import bridge_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  bridge_req_t req,
    input  logic        rd_done,
    input  logic        tx_done,
    input  logic        miso,
    output logic        rd_start,
    output dram_addr_t  rd_addr,
    output sd_addr_t    sd_addr,
    output logic        cmd_load,
    output logic        data_load,
    output logic        out_start
);

    ctrl_state_t state;
    sd_addr_t    sd_addr_q;
    logic [3:0]  bit_cnt;
    logic        resp_end;

    // request accepted only when idle
    assign rd_start = (state == st_idle) & in_valid;

    // reader takes the address on the accept cycle
    assign rd_addr = req.addr_dram;
    assign sd_addr = sd_addr_q;

    always_ff @(posedge clk) begin
        if (rd_start) begin
            sd_addr_q <= req.addr_sd;
        end
    end

    // last bit of a response byte being sampled
    assign resp_end = (bit_cnt == 4'(SD_RESP_BITS - 1));

    // ############################
    // state machine
    // ############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            bit_cnt   <= 4'd0;
            cmd_load  <= 1'b0;
            data_load <= 1'b0;
            out_start <= 1'b0;
        end else begin
            cmd_load  <= 1'b0;
            data_load <= 1'b0;
            out_start <= 1'b0;
            case (state)
                st_idle: begin
                    bit_cnt <= 4'd0;
                    if (in_valid) begin
                        state <= st_read;
                    end
                end
                st_read: begin
                    if (rd_done) begin
                        cmd_load <= 1'b1;
                        state    <= st_send_cmd;
                    end
                end
                st_send_cmd: begin
                    if (tx_done) begin
                        state <= st_cmd_resp;
                    end
                end
                // response bytes: first 0 starts the count, values ignored
                st_cmd_resp, st_data_resp: begin
                    if (bit_cnt == 4'd0) begin
                        if (!miso) begin
                            bit_cnt <= 4'd1;
                        end
                    end else if (resp_end) begin
                        bit_cnt <= 4'd0;
                        state   <= (state == st_cmd_resp) ? st_data_gap : st_busy;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                st_data_gap: begin
                    if (bit_cnt == 4'(SD_DATA_GAP - 1)) begin
                        bit_cnt   <= 4'd0;
                        data_load <= 1'b1;
                        state     <= st_send_data;
                    end else begin
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
                st_send_data: begin
                    if (tx_done) begin
                        state <= st_data_resp;
                    end
                end
                // card holds miso low while programming
                st_busy: begin
                    if (miso) begin
                        out_start <= 1'b1;
                        state     <= st_done;
                    end
                end
                st_done: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

// File: hw/sd_frame_tx.sv
// SD frame transmitter
// builds the CMD24 frame or the data frame with their CRCs
// and shifts it out on MOSI one bit per clock, msb first
`timescale 1ns/1ps

module sd_frame_tx import bridge_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     cmd_load,
    input  logic     data_load,
    input  sd_addr_t sd_addr,
    input  block_t   block,
    output logic     mosi,
    output logic     tx_done
);

    localparam int PAD_BITS = SD_DATA_BITS - SD_CMD_BITS;

    logic [SD_DATA_BITS-1:0] shift_q;
    logic [6:0]              bit_cnt;
    logic [39:0]             cmd_head;
    logic [SD_CMD_BITS-1:0]  cmd_frame;
    logic [SD_DATA_BITS-1:0] data_frame;
    logic                    active;

    // ############################
    // frame assembly
    // ############################
    // start bit, transmission bit, index, 32-bit argument
    assign cmd_head = {1'b0, 1'b1, SD_CMD_WRITE, 16'h0000, sd_addr};

    // crc7 then end bit
    assign cmd_frame = {cmd_head, crc7(cmd_head), 1'b1};

    assign data_frame = {SD_START_TOKEN, block, crc16_ccitt(block)};

    assign active = (bit_cnt != 7'd0);

    // ############################
    // shifter
    // ############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt <= 7'd0;
        end else if (cmd_load) begin
            bit_cnt <= 7'(SD_CMD_BITS);
        end else if (data_load) begin
            bit_cnt <= 7'(SD_DATA_BITS);
        end else if (active) begin
            bit_cnt <= bit_cnt - 7'd1;
        end
    end

    // command frame sits left-aligned, tail padded with idle ones
    always_ff @(posedge clk) begin
        if (cmd_load) begin
            shift_q <= {cmd_frame, {PAD_BITS{1'b1}}};
        end else if (data_load) begin
            shift_q <= data_frame;
        end else if (active) begin
            shift_q <= {shift_q[SD_DATA_BITS-2:0], 1'b1};
        end
    end

    // line idles high between frames
    assign mosi = active ? shift_q[SD_DATA_BITS-1] : 1'b1;

    // high together with the last bit
    assign tx_done = (bit_cnt == 7'd1);

endmodule

// File: hw/dram_reader.sv
// DRAM block reader
// issues one read address beat, waits for the read data beat
// and holds the captured 64-bit block for the SD and output paths
`timescale 1ns/1ps

module dram_reader import bridge_pkg::*; (
    input  logic         clk,
    input  logic         rst_n,
    input  logic         rd_start,
    input  dram_addr_t   rd_addr,
    input  dram_rd_rsp_t dram_rsp,
    output dram_rd_req_t dram_req,
    output logic         rd_done,
    output block_t       block
);

    logic      ar_valid;
    logic      r_ready;
    axi_addr_t ar_addr;
    logic      ar_fire;
    logic      r_fire;

    assign ar_fire = ar_valid & dram_rsp.ar_ready;
    assign r_fire  = r_ready & dram_rsp.r_valid;

    // ############################
    // handshake control
    // ############################
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ar_valid <= 1'b0;
            r_ready  <= 1'b0;
            rd_done  <= 1'b0;
        end else begin
            rd_done <= r_fire;
            if (rd_start) begin
                ar_valid <= 1'b1;
            end else if (ar_fire) begin
                ar_valid <= 1'b0;
            end
            // data phase opens right after the address beat
            if (ar_fire) begin
                r_ready <= 1'b1;
            end else if (r_fire) begin
                r_ready <= 1'b0;
            end
        end
    end

    // address and block payload
    always_ff @(posedge clk) begin
        if (rd_start) begin
            ar_addr <= axi_addr_t'(rd_addr);
        end
        if (r_fire) begin
            block <= dram_rsp.r_data;
        end
    end

    assign dram_req = '{ar_valid: ar_valid, ar_addr: ar_addr, r_ready: r_ready};

endmodule

// File: hw/bridge_pkg.sv
// DRAM to SD bridge shared definitions
// widths, bus structs, SD protocol constants, controller states
// and the CRC7 and CRC16-CCITT helpers used to build SD frames
package bridge_pkg;

    // ############################
    // widths
    // ############################
    localparam int DRAM_ADDR_W = 13;
    localparam int AXI_ADDR_W  = 32;
    localparam int SD_ADDR_W   = 16;
    localparam int BLOCK_W     = 64;
    localparam int BYTE_W      = 8;

    typedef logic [DRAM_ADDR_W-1:0] dram_addr_t;
    typedef logic [AXI_ADDR_W-1:0]  axi_addr_t;
    typedef logic [SD_ADDR_W-1:0]   sd_addr_t;
    typedef logic [BLOCK_W-1:0]     block_t;
    typedef logic [BYTE_W-1:0]      byte_t;

    typedef struct packed {
        dram_addr_t addr_dram;
        sd_addr_t   addr_sd;
    } bridge_req_t;

    // bridge to DRAM, read address and read data channels
    typedef struct packed {
        logic      ar_valid;
        axi_addr_t ar_addr;
        logic      r_ready;
    } dram_rd_req_t;

    // DRAM to bridge
    typedef struct packed {
        logic   ar_ready;
        logic   r_valid;
        block_t r_data;
    } dram_rd_rsp_t;

    // ############################
    // SD protocol, SPI mode
    // ############################
    localparam logic [5:0] SD_CMD_WRITE   = 6'd24;
    localparam int         SD_CMD_BITS    = 48;
    localparam int         SD_DATA_BITS   = 88;
    localparam byte_t      SD_START_TOKEN = 8'hFE;
    localparam int         SD_RESP_BITS   = 8;
    localparam int         SD_DATA_GAP    = 8;
    localparam int         BLOCK_BYTES    = 8;

    localparam logic [6:0]  CRC7_POLY  = 7'h09;
    localparam logic [15:0] CRC16_POLY = 16'h1021;

    typedef enum logic [3:0] {
        st_idle,
        st_read,
        st_send_cmd,
        st_cmd_resp,
        st_data_gap,
        st_send_data,
        st_data_resp,
        st_busy,
        st_done
    } ctrl_state_t;

    // bitwise crc over the command head, msb first
    function automatic logic [6:0] crc7(input logic [39:0] data);
        logic [6:0] crc;
        logic       fb;
        crc = '0;
        for (int i = 39; i >= 0; i--) begin
            fb  = data[i] ^ crc[6];
            crc = {crc[5:0], 1'b0};
            if (fb) begin
                crc = crc ^ CRC7_POLY;
            end
        end
        return crc;
    endfunction

    function automatic logic [15:0] crc16_ccitt(input block_t data);
        logic [15:0] crc;
        logic        fb;
        crc = '0;
        for (int i = BLOCK_W - 1; i >= 0; i--) begin
            fb  = data[i] ^ crc[15];
            crc = {crc[14:0], 1'b0};
            if (fb) begin
                crc = crc ^ CRC16_POLY;
            end
        end
        return crc;
    endfunction

endpackage
